// ==== hdl/dp_mem_defs.svh ====
// Sizes and address windows for the datapath data memory
// Word and address widths, bank A and bank B memory windows,
// and the I/O port window shared by both banks

`ifndef DP_MEM_DEFS_SVH
`define DP_MEM_DEFS_SVH

// ------------------------------
// Widths
// ------------------------------

`define DP_WORD_WIDTH       16

// Read and write address space, already translated
`define DP_ADDR_WIDTH       10

// Local RAM index, taken from the low address bits
`define DP_MEM_ADDR_WIDTH   8

// ------------------------------
// Bank memory windows
// ------------------------------

// Address 0 is below both windows and acts as the zero location
`define DP_A_BASE           1
`define DP_A_BOUND          255

// Bank B fills only half of its index range
`define DP_B_BASE           1
`define DP_B_BOUND          127

// ------------------------------
// I/O window
// ------------------------------

// Ports sit at the very top of the address space
`define DP_IO_BASE          1020
`define DP_IO_COUNT         4

`endif

// ==== hdl/dp_mem_pkg.sv ====
// Types shared by the datapath data memory and its testbench
// Address decode result, read and write requests, I/O port bus

`include "dp_mem_defs.svh"

package dp_mem_pkg;

    // ------------------------------
    // Address decode result
    // ------------------------------

    // What one qualified address turns into
    typedef enum logic [1:0] {
        ACC_NONE = 2'd0,
        ACC_MEM  = 2'd1,
        ACC_IO   = 2'd2
    } access_kind_t;

    // ------------------------------
    // Requests
    // ------------------------------

    // Read request, one translated address
    typedef struct packed {
        logic [`DP_ADDR_WIDTH-1:0]  addr;
    } rd_req_t;

    // Write request coming from the ALU
    typedef struct packed {
        logic [`DP_ADDR_WIDTH-1:0]  addr;
        logic [`DP_WORD_WIDTH-1:0]  data;
    } wr_req_t;

    // ------------------------------
    // I/O ports
    // ------------------------------

    // One word per port, used for port inputs and port outputs alike
    typedef struct packed {
        logic [`DP_IO_COUNT-1:0][`DP_WORD_WIDTH-1:0]  port;
    } io_bus_t;

endpackage

// ==== hdl/mem_range_check.sv ====
// Address window decode for one data memory bank
// Classifies a read and a write address as memory, I/O or nothing,
// qualified by the status of the instruction that owns each access

`timescale 1ns/1ns

`include "dp_mem_defs.svh"

module mem_range_check
    import dp_mem_pkg::*;
#(
    parameter int BASE  = `DP_A_BASE,
    parameter int BOUND = `DP_A_BOUND
)
(
    // Read side, current instruction
    input  logic [`DP_ADDR_WIDTH-1:0]   rd_addr,
    input  logic                        rd_ior,
    input  logic                        rd_cancel,
    output access_kind_t                rd_kind,

    // Write side, previous instruction
    input  logic [`DP_ADDR_WIDTH-1:0]   wr_addr,
    input  logic                        wr_ior,
    input  logic                        wr_cancel,
    output access_kind_t                wr_kind
);

    // Anything outside both windows, or under a bad status, is no access
    function automatic access_kind_t decode(input logic [`DP_ADDR_WIDTH-1:0] addr,
                                            input logic ior,
                                            input logic cancel);
        int           a;
        access_kind_t kind;
        a    = int'(addr);
        kind = ACC_NONE;
        if (ior && !cancel) begin
            if (a >= BASE && a <= BOUND) begin
                kind = ACC_MEM;
            end else if (a >= `DP_IO_BASE && a < `DP_IO_BASE + `DP_IO_COUNT) begin
                kind = ACC_IO;
            end
        end
        return kind;
    endfunction

    assign rd_kind = decode(rd_addr, rd_ior, rd_cancel);
    assign wr_kind = decode(wr_addr, wr_ior, wr_cancel);

    // ------------------------------
    // Window sanity
    // ------------------------------

    // The memory window must fit the local index and stay clear of the I/O ports
    initial begin
        assert (BASE <= BOUND && BOUND < (1 << `DP_MEM_ADDR_WIDTH))
            else $error("memory window %0d..%0d does not fit the RAM index", BASE, BOUND);
        assert (BOUND < `DP_IO_BASE)
            else $error("memory window bound %0d overlaps the I/O window", BOUND);
    end

endmodule

// ==== hdl/io_port_select.sv ====
// I/O port selection for one access
// Turns an I/O access into a one-hot port strobe and a port index

`timescale 1ns/1ns

`include "dp_mem_defs.svh"

module io_port_select
    import dp_mem_pkg::*;
(
    input  logic                        clock,
    input  access_kind_t                kind,
    input  logic [`DP_ADDR_WIDTH-1:0]   addr,
    output logic [`DP_IO_COUNT-1:0]     sel,
    output logic [1:0]                  index
);

    // Position of the address inside the I/O window
    logic [`DP_ADDR_WIDTH-1:0] offset;

    assign offset = addr - `DP_ADDR_WIDTH'(`DP_IO_BASE);
    assign index  = offset[1:0];

    // Only a qualified I/O access lights a port
    always_comb begin
        sel = '0;
        if (kind == ACC_IO) begin
            sel[index] = 1'b1;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // The window decode upstream never hands over an offset past the last port
    assert property (@(posedge clock)
        (kind == ACC_IO) |-> (int'(offset) < `DP_IO_COUNT))
        else $error("io_port_select: I/O offset %0d outside the port range", offset);

endmodule

// ==== hdl/data_memory.sv ====
// One bank of the datapath data memory
// Window decode, RAM with registered read, zero location,
// I/O read mux, I/O write holding registers and write strobes

`timescale 1ns/1ns

`include "dp_mem_defs.svh"

module data_memory
    import dp_mem_pkg::*;
#(
    parameter int BASE  = `DP_A_BASE,
    parameter int BOUND = `DP_A_BOUND
)
(
    input  logic                        clock,
    input  logic                        rst_n,

    // Current and previous instruction status
    input  logic                        ior,
    input  logic                        cancel,
    input  logic                        ior_previous,
    input  logic                        cancel_previous,

    // Translated addresses and ALU write data
    input  rd_req_t                     rd,
    input  wr_req_t                     wr,

    // Outside world
    input  io_bus_t                     io_read_data,
    output io_bus_t                     io_write_data,
    output logic [`DP_IO_COUNT-1:0]     io_wren,

    // Final read word, from RAM, I/O or zero
    output logic [`DP_WORD_WIDTH-1:0]   read_data
);

    access_kind_t                   rd_kind;
    access_kind_t                   wr_kind;
    logic [`DP_IO_COUNT-1:0]        rd_sel;
    logic [`DP_IO_COUNT-1:0]        wr_sel;
    logic [1:0]                     rd_index;
    logic [1:0]                     wr_index;
    logic [`DP_MEM_ADDR_WIDTH-1:0]  rd_local;
    logic [`DP_MEM_ADDR_WIDTH-1:0]  wr_local;

    // Only the window itself is stored, BOUND-BASE+1 words
    logic [`DP_WORD_WIDTH-1:0]      ram [BASE:BOUND];

    // ------------------------------
    // Decode
    // ------------------------------

    // Reads belong to this instruction, writes to the one before
    mem_range_check #(
        .BASE       (BASE),
        .BOUND      (BOUND)
    ) range_check (
        .rd_addr    (rd.addr),
        .rd_ior     (ior),
        .rd_cancel  (cancel),
        .rd_kind    (rd_kind),
        .wr_addr    (wr.addr),
        .wr_ior     (ior_previous),
        .wr_cancel  (cancel_previous),
        .wr_kind    (wr_kind)
    );

    io_port_select rd_port (
        .clock      (clock),
        .kind       (rd_kind),
        .addr       (rd.addr),
        .sel        (rd_sel),
        .index      (rd_index)
    );

    io_port_select wr_port (
        .clock      (clock),
        .kind       (wr_kind),
        .addr       (wr.addr),
        .sel        (wr_sel),
        .index      (wr_index)
    );

    // Window is power-of-two aligned, so the high bits just drop
    assign rd_local = rd.addr[`DP_MEM_ADDR_WIDTH-1:0];
    assign wr_local = wr.addr[`DP_MEM_ADDR_WIDTH-1:0];

    // ------------------------------
    // RAM
    // ------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = BASE; i <= BOUND; i++) begin
                ram[i] <= '0;
            end
        end else if (wr_kind == ACC_MEM) begin
            ram[wr_local] <= wr.data;
        end
    end

    // Read return; a same-edge write is not seen, old data comes back
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (rd_kind == ACC_MEM) begin
            read_data <= ram[rd_local];
        end else if (|rd_sel) begin
            read_data <= io_read_data.port[rd_index];
        end else begin
            read_data <= '0;
        end
    end

    // ------------------------------
    // I/O write ports
    // ------------------------------

    // Strobe lasts one cycle, the word holds until the next write to that port
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_wren       <= '0;
            io_write_data <= '0;
        end else begin
            io_wren <= wr_sel;
            if (|wr_sel) begin
                io_write_data.port[wr_index] <= wr.data;
            end
        end
    end

    // No strobe may follow a write that was not decoded as I/O
    assert property (@(posedge clock) disable iff (!rst_n)
        (wr_kind != ACC_IO) |=> (io_wren == '0))
        else $error("data_memory: io_wren raised without an I/O write");

endmodule

// ==== hdl/datapath_memory.sv ====
// Datapath data memory, banks A and B
// Both banks see the same instruction status and decode independently

`timescale 1ns/1ns

`include "dp_mem_defs.svh"

module datapath_memory
    import dp_mem_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,

    // Instruction status, current for reads and previous for writes
    input  logic                        ior,
    input  logic                        cancel,
    input  logic                        ior_previous,
    input  logic                        cancel_previous,

    // Translated addresses and ALU write data
    input  rd_req_t                     rd_a,
    input  rd_req_t                     rd_b,
    input  wr_req_t                     wr_a,
    input  wr_req_t                     wr_b,

    // I/O ports
    input  io_bus_t                     io_read_data_a,
    input  io_bus_t                     io_read_data_b,
    output io_bus_t                     io_write_data_a,
    output io_bus_t                     io_write_data_b,
    output logic [`DP_IO_COUNT-1:0]     io_wren_a,
    output logic [`DP_IO_COUNT-1:0]     io_wren_b,

    // Read results, one cycle after the address
    output logic [`DP_WORD_WIDTH-1:0]   read_data_a,
    output logic [`DP_WORD_WIDTH-1:0]   read_data_b
);

    // ------------------------------
    // Bank A
    // ------------------------------

    data_memory #(
        .BASE               (`DP_A_BASE),
        .BOUND              (`DP_A_BOUND)
    ) bank_a (
        .clock              (clock),
        .rst_n              (rst_n),
        .ior                (ior),
        .cancel             (cancel),
        .ior_previous       (ior_previous),
        .cancel_previous    (cancel_previous),
        .rd                 (rd_a),
        .wr                 (wr_a),
        .io_read_data       (io_read_data_a),
        .io_write_data      (io_write_data_a),
        .io_wren            (io_wren_a),
        .read_data          (read_data_a)
    );

    // ------------------------------
    // Bank B
    // ------------------------------

    // Shallower window, upper half of the index range reads as zero
    data_memory #(
        .BASE               (`DP_B_BASE),
        .BOUND              (`DP_B_BOUND)
    ) bank_b (
        .clock              (clock),
        .rst_n              (rst_n),
        .ior                (ior),
        .cancel             (cancel),
        .ior_previous       (ior_previous),
        .cancel_previous    (cancel_previous),
        .rd                 (rd_b),
        .wr                 (wr_b),
        .io_read_data       (io_read_data_b),
        .io_write_data      (io_write_data_b),
        .io_wren            (io_wren_b),
        .read_data          (read_data_b)
    );

endmodule

// ==== bench/tb_datapath_memory.sv ====
// Testbench for the datapath data memory
// Random stimulus from a fixed seed on both banks, a reference model of
// the two RAMs and the I/O ports, typed compare tasks, per-test reporting
// and a cycle limit

`timescale 1ns/1ns

`include "dp_mem_defs.svh"

module tb_datapath_memory
    import dp_mem_pkg::*;
();

    // Test lengths in cycles
    localparam int RESET_CYCLES     = 4;
    localparam int ZERO_READ_CYCLES = 40;
    localparam int MEM_CYCLES       = 400;
    localparam int EDGE_CYCLES      = 200;
    localparam int GATE_CYCLES      = 300;
    localparam int IO_CYCLES        = 300;
    localparam int CYCLE_LIMIT      = RESET_CYCLES + ZERO_READ_CYCLES + MEM_CYCLES
                                    + EDGE_CYCLES + GATE_CYCLES + IO_CYCLES + 50;

    // Address mixes
    localparam int M_ZERO = 0;
    localparam int M_MEM  = 1;
    localparam int M_OUT  = 2;
    localparam int M_EDGE = 3;
    localparam int M_MIX  = 4;
    localparam int M_IO   = 5;

    logic                       clock;
    logic                       rst_n;
    logic                       ior;
    logic                       cancel;
    logic                       ior_previous;
    logic                       cancel_previous;
    rd_req_t                    rd_a;
    rd_req_t                    rd_b;
    wr_req_t                    wr_a;
    wr_req_t                    wr_b;
    io_bus_t                    io_read_data_a;
    io_bus_t                    io_read_data_b;
    io_bus_t                    io_write_data_a;
    io_bus_t                    io_write_data_b;
    logic [`DP_IO_COUNT-1:0]    io_wren_a;
    logic [`DP_IO_COUNT-1:0]    io_wren_b;
    logic [`DP_WORD_WIDTH-1:0]  read_data_a;
    logic [`DP_WORD_WIDTH-1:0]  read_data_b;

    // Reference model, index 0 is bank A and 1 is bank B
    logic [`DP_WORD_WIDTH-1:0]  model_mem [2][256];
    logic [`DP_WORD_WIDTH-1:0]  exp_rd [2];
    io_bus_t                    exp_io [2];
    logic [`DP_IO_COUNT-1:0]    exp_wren [2];

    int seed;
    int checks;
    int errors;
    int test_errors;
    int cycle_count;

    datapath_memory dut0 (
        .clock              (clock),
        .rst_n              (rst_n),
        .ior                (ior),
        .cancel             (cancel),
        .ior_previous       (ior_previous),
        .cancel_previous    (cancel_previous),
        .rd_a               (rd_a),
        .rd_b               (rd_b),
        .wr_a               (wr_a),
        .wr_b               (wr_b),
        .io_read_data_a     (io_read_data_a),
        .io_read_data_b     (io_read_data_b),
        .io_write_data_a    (io_write_data_a),
        .io_write_data_b    (io_write_data_b),
        .io_wren_a          (io_wren_a),
        .io_wren_b          (io_wren_b),
        .read_data_a        (read_data_a),
        .read_data_b        (read_data_b)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ------------------------------
    // Random helpers
    // ------------------------------

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic int window_base(input int bank);
        return (bank == 0) ? `DP_A_BASE : `DP_B_BASE;
    endfunction

    function automatic int window_bound(input int bank);
        return (bank == 0) ? `DP_A_BOUND : `DP_B_BOUND;
    endfunction

    // Zero location, anything past the bound up to the ports, or just past the bound
    function automatic int out_addr(input int hi);
        int kind;
        kind = pick(3);
        if (kind == 0)
            return 0;
        else if (kind == 1)
            return hi + 1 + pick(`DP_IO_BASE - hi - 1);
        return hi + 1 + pick(256 - hi);
    endfunction

    function automatic logic [`DP_ADDR_WIDTH-1:0] gen_addr(input int mode, input int bank);
        int lo;
        int hi;
        int sel;
        int a;
        lo  = window_base(bank);
        hi  = window_bound(bank);
        sel = pick(10);
        case (mode)
            M_ZERO:  a = 0;
            // Half of the accesses crowd a few words to force same-address hits
            M_MEM:   a = (sel < 5) ? lo + pick(8) : lo + pick(hi - lo + 1);
            M_OUT:   a = out_addr(hi);
            M_EDGE:  a = (sel < 5) ? lo + pick(hi - lo + 1) : out_addr(hi);
            M_MIX:   a = (sel < 4) ? lo + pick(hi - lo + 1)
                       : (sel < 7) ? out_addr(hi) : `DP_IO_BASE + pick(`DP_IO_COUNT);
            default: a = (sel < 7) ? `DP_IO_BASE + pick(`DP_IO_COUNT)
                                   : lo + pick(hi - lo + 1);
        endcase
        return `DP_ADDR_WIDTH'(a);
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic access_kind_t classify(input int bank,
                                              input logic [`DP_ADDR_WIDTH-1:0] addr,
                                              input logic ok);
        int a;
        a = int'(addr);
        if (!ok)
            return ACC_NONE;
        if (a >= window_base(bank) && a <= window_bound(bank))
            return ACC_MEM;
        if (a >= `DP_IO_BASE && a < `DP_IO_BASE + `DP_IO_COUNT)
            return ACC_IO;
        return ACC_NONE;
    endfunction

    // One rising edge; reads see the memory before this edge's writes
    task automatic model_edge();
        rd_req_t      r [2];
        wr_req_t      w [2];
        io_bus_t      pin [2];
        access_kind_t k;
        int           p;
        r[0]   = rd_a;
        r[1]   = rd_b;
        w[0]   = wr_a;
        w[1]   = wr_b;
        pin[0] = io_read_data_a;
        pin[1] = io_read_data_b;
        for (int b = 0; b < 2; b++) begin
            if (!rst_n) begin
                for (int i = 0; i < 256; i++)
                    model_mem[b][i] = '0;
                exp_rd[b]   = '0;
                exp_io[b]   = '0;
                exp_wren[b] = '0;
            end else begin
                k = classify(b, r[b].addr, ior && !cancel);
                p = int'(r[b].addr) - `DP_IO_BASE;
                if (k == ACC_MEM)
                    exp_rd[b] = model_mem[b][r[b].addr[`DP_MEM_ADDR_WIDTH-1:0]];
                else if (k == ACC_IO)
                    exp_rd[b] = pin[b].port[p];
                else
                    exp_rd[b] = '0;
                k = classify(b, w[b].addr, ior_previous && !cancel_previous);
                p = int'(w[b].addr) - `DP_IO_BASE;
                exp_wren[b] = '0;
                if (k == ACC_MEM) begin
                    model_mem[b][w[b].addr[`DP_MEM_ADDR_WIDTH-1:0]] = w[b].data;
                end else if (k == ACC_IO) begin
                    exp_wren[b][p]     = 1'b1;
                    exp_io[b].port[p]  = w[b].data;
                end
            end
        end
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_word(input string name, input logic [`DP_WORD_WIDTH-1:0] expected,
                              input logic [`DP_WORD_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_io_bus(input string name, input io_bus_t expected, input io_bus_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_wren(input string name, input logic [`DP_IO_COUNT-1:0] expected,
                              input logic [`DP_IO_COUNT-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Called at a falling edge; drives, lets one rising edge pass, then compares
    task automatic step(input int rd_mode, input int wr_mode, input bit gated);
        ior_previous    = ior;
        cancel_previous = cancel;
        if (gated) begin
            ior    = (pick(4) != 0);
            cancel = (pick(2) != 0);
        end else begin
            ior    = 1'b1;
            cancel = 1'b0;
        end
        rd_a.addr = gen_addr(rd_mode, 0);
        rd_b.addr = gen_addr(rd_mode, 1);
        wr_a.addr = gen_addr(wr_mode, 0);
        wr_b.addr = gen_addr(wr_mode, 1);
        wr_a.data = `DP_WORD_WIDTH'($random(seed));
        wr_b.data = `DP_WORD_WIDTH'($random(seed));
        for (int i = 0; i < `DP_IO_COUNT; i++) begin
            io_read_data_a.port[i] = `DP_WORD_WIDTH'($random(seed));
            io_read_data_b.port[i] = `DP_WORD_WIDTH'($random(seed));
        end
        @(posedge clock);
        model_edge();
        @(negedge clock);
        check_word("read_data_a", exp_rd[0], read_data_a);
        check_word("read_data_b", exp_rd[1], read_data_b);
        check_io_bus("io_write_data_a", exp_io[0], io_write_data_a);
        check_io_bus("io_write_data_b", exp_io[1], io_write_data_b);
        check_wren("io_wren_a", exp_wren[0], io_wren_a);
        check_wren("io_wren_b", exp_wren[1], io_wren_b);
    endtask

    task automatic finish_test(input string name, input int cycles);
        $display("%-8s %0d cycles, %0d errors", name, cycles, test_errors);
        test_errors = 0;
    endtask

    task automatic run_test(input string name, input int cycles, input int rd_mode,
                            input int wr_mode, input bit gated);
        repeat (cycles) step(rd_mode, wr_mode, gated);
        finish_test(name, cycles);
    endtask

    initial begin
        seed            = 84;
        checks          = 0;
        errors          = 0;
        test_errors     = 0;
        rst_n           = 1'b0;
        ior             = 1'b0;
        cancel          = 1'b0;
        ior_previous    = 1'b0;
        cancel_previous = 1'b0;
        rd_a            = '0;
        rd_b            = '0;
        wr_a            = '0;
        wr_b            = '0;
        io_read_data_a  = '0;
        io_read_data_b  = '0;

        // Reset, then reads across both windows with writes parked at address 0
        repeat (RESET_CYCLES) step(M_MIX, M_MIX, 1'b1);
        rst_n = 1'b1;
        repeat (ZERO_READ_CYCLES) step(M_MEM, M_ZERO, 1'b0);
        finish_test("reset", RESET_CYCLES + ZERO_READ_CYCLES);

        run_test("mem_rw", MEM_CYCLES, M_MEM, M_MEM, 1'b0);
        run_test("limits", EDGE_CYCLES, M_EDGE, M_OUT, 1'b0);
        run_test("gating", GATE_CYCLES, M_MIX, M_MIX, 1'b1);
        run_test("io_ports", IO_CYCLES, M_IO, M_IO, 1'b0);

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Stops a run that never reaches the end of the tests
    initial begin
        cycle_count = 0;
        while (cycle_count <= CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/dp_mem_pkg.sv
hdl/mem_range_check.sv
hdl/io_port_select.sv
hdl/data_memory.sv
hdl/datapath_memory.sv
bench/tb_datapath_memory.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_datapath_memory
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
